// File: rv_core.f
logic/rv_pkg.sv
logic/fetch_stage.sv
logic/decode_ctrl.sv
logic/reg_file.sv
logic/hazard_unit.sv
logic/branch_unit.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/rv_core.sv
sim/tb_clock.sv
sim/tb_rv_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rv_core -f rv_core.f -o sim_rv_core \
    || { echo "build failed"; exit 1; }

./obj_dir/sim_rv_core | tee /dev/stderr | grep -qx '>>> PASS' \
    && exit 0 \
    || exit 1

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    logic          clk;
    logic          rst;
    rv_pkg::word_t imem_addr;
    rv_pkg::word_t imem_data;
    rv_pkg::word_t dmem_addr;
    rv_pkg::word_t dmem_wdata;
    logic          dmem_re;
    logic          dmem_we;
    rv_pkg::word_t dmem_rdata;

    rv_pkg::word_t prog [256];
    rv_pkg::word_t dmem [64];
    rv_pkg::word_t ref_mem [64];
    rv_pkg::word_t exp_addr [$];
    rv_pkg::word_t exp_data [$];
    int            n_inst;
    int            seed;
    int            value_errors;
    int            other_errors;
    logic          done;

    tb_clock clock_i (.clk(clk), .rst(rst));

    rv_core dut_i (
        .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re),
        .dmem_we(dmem_we), .dmem_rdata(dmem_rdata)
    );

    // memory models
    assign imem_data  = prog[imem_addr[9:2]];
    assign dmem_rdata = dmem_re ? dmem[dmem_addr[7:2]] : '0;

    always @(posedge clk) begin
        if (!rst && dmem_we)
            dmem[dmem_addr[7:2]] <= dmem_wdata;
    end

    // ========================================
    // instruction encoders
    // ========================================
    function automatic rv_pkg::word_t enc_r(input logic [6:0] f7, input int rs2,
                                            input int rs1, input int rd);
        return {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), rv_pkg::op_r_type};
    endfunction

    function automatic rv_pkg::word_t enc_addi(input logic [11:0] imm, input int rs1,
                                               input int rd);
        return {imm, 5'(rs1), 3'b000, 5'(rd), rv_pkg::op_i_type};
    endfunction

    function automatic rv_pkg::word_t enc_lw(input logic [11:0] imm, input int rs1,
                                             input int rd);
        return {imm, 5'(rs1), 3'b010, 5'(rd), rv_pkg::op_load};
    endfunction

    function automatic rv_pkg::word_t enc_sw(input logic [11:0] imm, input int rs2,
                                             input int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::word_t enc_b(input logic [2:0] f3, input int rs1,
                                            input int rs2, input logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11],
                rv_pkg::op_branch};
    endfunction

    task automatic emit(input rv_pkg::word_t w);
        prog[n_inst] = w;
        n_inst++;
    endtask

    // x7 ends up k when taken, k+100 when not
    task automatic branch_group(input logic [2:0] f3, input int a, input int b, input int k);
        emit(enc_addi(12'(k), 0, 7));
        emit(enc_b(f3, a, b, 13'd8));
        emit(enc_addi(12'd100, 7, 7));
        emit(enc_sw(12'h040, 7, 0));
    endtask

    // ========================================
    // reference interpreter
    // ========================================
    function automatic int interpret_program();
        rv_pkg::word_t x [32];
        rv_pkg::word_t pc;
        rv_pkg::word_t inst;
        rv_pkg::word_t a;
        rv_pkg::word_t b;
        rv_pkg::word_t imm_i;
        rv_pkg::word_t imm_s;
        rv_pkg::word_t imm_b;
        logic          take;
        int            steps;
        pc = rv_pkg::reset_pc;
        steps = 0;
        for (int i = 0; i < 32; i++)
            x[i] = '0;
        while (steps < 1000) begin
            inst  = prog[pc[9:2]];
            a     = x[inst[19:15]];
            b     = x[inst[24:20]];
            imm_i = {{20{inst[31]}}, inst[31:20]};
            imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            take  = 1'b0;
            case (inst[6:0])
                7'b0110011: x[inst[11:7]] = (inst[31:25] == 7'b0100000) ? a - b : a + b;
                7'b0010011: x[inst[11:7]] = a + imm_i;
                7'b0000011: x[inst[11:7]] = ref_mem[(a + imm_i) >> 2 & 63];
                7'b0100011: begin
                    exp_addr.push_back(a + imm_s);
                    exp_data.push_back(b);
                    ref_mem[(a + imm_s) >> 2 & 63] = b;
                    if (a + imm_s == 32'hFC)
                        return exp_addr.size();
                end
                7'b1100011: begin
                    case (inst[14:12])
                        3'b000: take = (a == b);
                        3'b001: take = (a != b);
                        3'b100: take = ($signed(a) < $signed(b));
                        3'b101: take = ($signed(a) >= $signed(b));
                        3'b110: take = (a < b);
                        3'b111: take = (a >= b);
                        default: take = 1'b0;
                    endcase
                end
                default: ;
            endcase
            x[0] = '0;
            pc = take ? pc + imm_b : pc + 4;
            steps++;
        end
        return exp_addr.size();
    endfunction

    // ========================================
    // checking
    // ========================================
    always @(negedge clk) begin
        if (rst) begin
            assert (!dmem_we && !dmem_re && imem_addr == rv_pkg::reset_pc) else begin
                other_errors++;
                $display("strobe active or fetch address off reset_pc during reset");
            end
        end else if (dmem_we && !done) begin
            if (exp_addr.size() == 0) begin
                other_errors++;
                $display("store seen after the expected store list ran out");
            end else begin
                assert (dmem_addr == exp_addr[0]) else begin
                    value_errors++;
                    $display("** Error dmem_addr: got %h expected %h", dmem_addr, exp_addr[0]);
                end
                assert (dmem_wdata == exp_data[0]) else begin
                    value_errors++;
                    $display("** Error dmem_wdata: got %h expected %h",
                             dmem_wdata, exp_data[0]);
                end
                if (exp_addr[0] == 32'hFC)
                    done = 1'b1;
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        logic [11:0] r1;
        logic [11:0] r2;
        int          cycles;
        value_errors = 0;
        other_errors = 0;
        done   = 1'b0;
        n_inst = 0;
        seed   = 89726;
        r1 = 12'($random(seed));
        r2 = 12'($random(seed));
        for (int i = 0; i < 256; i++)
            prog[i] = rv_pkg::nop_inst;
        for (int i = 0; i < 64; i++) begin
            dmem[i]    = {16'h5A5A ^ 16'(i * 4), ~16'(i * 4)};  // fill keyed by address
            ref_mem[i] = dmem[i];
        end
        emit(enc_addi(r1, 0, 1));
        emit(enc_addi(r2, 0, 2));
        emit(enc_addi(-12'sd5, 0, 3));
        emit(enc_addi(12'd7, 0, 4));
        // dependent chain
        emit(enc_r(7'b0000000, 2, 1, 5));
        emit(enc_r(7'b0100000, 1, 5, 6));  // from MEM
        emit(enc_addi(12'd3, 5, 8));       // from WB
        emit(enc_r(7'b0000000, 8, 6, 9));
        emit(enc_sw(12'h000, 5, 0));
        emit(enc_sw(12'h004, 6, 0));
        emit(enc_sw(12'h008, 8, 0));
        emit(enc_sw(12'h00C, 9, 0));
        // load then use
        emit(enc_sw(12'h010, 9, 0));
        emit(enc_lw(12'h010, 0, 10));
        emit(enc_r(7'b0000000, 1, 10, 11));
        emit(enc_sw(12'h014, 11, 0));
        emit(enc_lw(12'h080, 0, 12));
        emit(enc_addi(12'd1, 12, 13));
        emit(enc_sw(12'h018, 13, 0));
        // six branches, both ways, signed and unsigned pairs
        branch_group(rv_pkg::f3_beq, 4, 4, 1);
        branch_group(rv_pkg::f3_beq, 3, 4, 2);
        branch_group(rv_pkg::f3_bne, 3, 4, 3);
        branch_group(rv_pkg::f3_bne, 4, 4, 4);
        branch_group(rv_pkg::f3_blt, 3, 4, 5);
        branch_group(rv_pkg::f3_blt, 4, 3, 6);
        branch_group(rv_pkg::f3_bge, 4, 3, 7);
        branch_group(rv_pkg::f3_bge, 3, 4, 8);
        branch_group(rv_pkg::f3_bltu, 4, 3, 9);
        branch_group(rv_pkg::f3_bltu, 3, 4, 10);
        branch_group(rv_pkg::f3_bgeu, 3, 4, 11);
        branch_group(rv_pkg::f3_bgeu, 4, 3, 12);
        // branch two after a load, then branch right after its producer
        emit(enc_lw(12'h004, 0, 14));
        emit(enc_addi(12'd50, 0, 7));
        emit(enc_b(rv_pkg::f3_beq, 14, 6, 13'd8));
        emit(enc_addi(12'd100, 7, 7));
        emit(enc_sw(12'h044, 7, 0));
        emit(enc_addi(-12'sd7, 3, 16));
        emit(enc_b(rv_pkg::f3_bne, 16, 0, 13'd8));
        emit(enc_addi(12'd1, 7, 7));
        emit(enc_sw(12'h048, 7, 0));
        // x0 stays zero
        emit(enc_addi(12'd55, 0, 0));
        emit(enc_r(7'b0000000, 2, 1, 0));
        emit(enc_sw(12'h04C, 0, 0));
        emit(enc_sw(12'h0FC, 1, 0));  // done marker
        void'(interpret_program());

        // first falling edge after reset drops, before the pc can move
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rst && cycles < 20);
        if (rst) begin
            other_errors++;
            $display("timed out waiting for reset to drop");
        end
        assert (imem_addr == rv_pkg::reset_pc && !dmem_we && !dmem_re) else begin
            other_errors++;
            $display("fetch did not start at reset_pc with strobes idle");
        end

        cycles = 0;
        while (!done && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done) begin
            other_errors++;
            $display("timed out waiting for the done store");
        end
        @(negedge clk);
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core (
    input  logic          clk,
    input  logic          rst,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_re,
    output logic          dmem_we,
    input  rv_pkg::word_t dmem_rdata
);

    // IF / ID
    rv_pkg::word_t      if_pc;
    rv_pkg::word_t      if_inst;
    rv_pkg::ex_ctrl_t   id_ctrl;
    rv_pkg::word_t      id_imm;
    rv_pkg::word_t      rs1_data;
    rv_pkg::word_t      rs2_data;
    logic               stall;
    logic               branch_taken;
    rv_pkg::word_t      branch_target;

    // EX
    rv_pkg::word_t      ex_alu_result;
    rv_pkg::reg_addr_t  ex_rd;
    logic               ex_reg_write;
    logic               ex_mem_read;
    rv_pkg::ex_ctrl_t   exm_ctrl;
    rv_pkg::word_t      exm_alu_out;
    rv_pkg::word_t      exm_store_data;
    rv_pkg::reg_addr_t  exm_rd;

    // MEM / WB
    rv_pkg::reg_addr_t  mem_rd;
    logic               mem_reg_write;
    logic               mem_mem_read;
    rv_pkg::word_t      mem_alu_out;
    rv_pkg::reg_addr_t  wb_rd;
    logic               wb_reg_write;
    rv_pkg::word_t      wb_data;

    fetch_stage fetch_i (
        .clk(clk), .rst(rst), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .imem_data(imem_data), .imem_addr(imem_addr),
        .if_pc(if_pc), .if_inst(if_inst)
    );

    decode_ctrl decode_i (.if_inst(if_inst), .id_ctrl(id_ctrl), .id_imm(id_imm));

    reg_file regs_i (
        .clk(clk), .rst(rst),
        .rs1_addr(if_inst[19:15]), .rs2_addr(if_inst[24:20]),
        .rd_addr(wb_rd), .w_data(wb_data), .reg_write(wb_reg_write),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    hazard_unit hazard_i (
        .if_inst(if_inst), .ex_rd(ex_rd), .mem_rd(mem_rd),
        .ex_mem_read(ex_mem_read), .mem_mem_read(mem_mem_read), .stall(stall)
    );

    branch_unit branch_i (
        .if_inst(if_inst), .if_pc(if_pc), .id_imm(id_imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .ex_alu_result(ex_alu_result), .mem_alu_out(mem_alu_out), .wb_data(wb_data),
        .ex_rd(ex_rd), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .ex_reg_write(ex_reg_write), .mem_reg_write(mem_reg_write),
        .wb_reg_write(wb_reg_write), .stall(stall),
        .branch_taken(branch_taken), .branch_target(branch_target)
    );

    execute_stage execute_i (
        .clk(clk), .rst(rst), .stall(stall), .id_ctrl(id_ctrl),
        .if_inst(if_inst), .id_imm(id_imm), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .mem_alu_out(mem_alu_out), .wb_data(wb_data), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .mem_reg_write(mem_reg_write), .wb_reg_write(wb_reg_write),
        .ex_alu_result(ex_alu_result), .ex_store_data(), .ex_rd(ex_rd),
        .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
        .exm_ctrl(exm_ctrl), .exm_alu_out(exm_alu_out),
        .exm_store_data(exm_store_data), .exm_rd(exm_rd)
    );

    mem_wb_stage mem_wb_i (
        .clk(clk), .rst(rst), .exm_ctrl(exm_ctrl), .exm_alu_out(exm_alu_out),
        .exm_store_data(exm_store_data), .exm_rd(exm_rd), .dmem_rdata(dmem_rdata),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_re(dmem_re), .dmem_we(dmem_we),
        .mem_rd(mem_rd), .mem_reg_write(mem_reg_write), .mem_mem_read(mem_mem_read),
        .mem_alu_out(mem_alu_out), .wb_rd(wb_rd), .wb_reg_write(wb_reg_write),
        .wb_data(wb_data)
    );

endmodule

// File: logic/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::ex_ctrl_t  exm_ctrl,
    input  rv_pkg::word_t     exm_alu_out,
    input  rv_pkg::word_t     exm_store_data,
    input  rv_pkg::reg_addr_t exm_rd,
    input  rv_pkg::word_t     dmem_rdata,
    output rv_pkg::word_t     dmem_addr,
    output rv_pkg::word_t     dmem_wdata,
    output logic              dmem_re,
    output logic              dmem_we,
    output rv_pkg::reg_addr_t mem_rd,
    output logic              mem_reg_write,
    output logic              mem_mem_read,
    output rv_pkg::word_t     mem_alu_out,
    output rv_pkg::reg_addr_t wb_rd,
    output logic              wb_reg_write,
    output rv_pkg::word_t     wb_data
);

    logic          wb_mem_to_reg;
    rv_pkg::word_t wb_alu_out;
    rv_pkg::word_t wb_load_data;

    // single-cycle strobes, read data same cycle
    assign dmem_addr  = exm_alu_out;
    assign dmem_wdata = exm_store_data;
    assign dmem_re    = exm_ctrl.mem_read;
    assign dmem_we    = exm_ctrl.mem_write;

    // MEM view for hazards and forwarding
    assign mem_rd        = exm_rd;
    assign mem_reg_write = exm_ctrl.reg_write;
    assign mem_mem_read  = exm_ctrl.mem_read;
    assign mem_alu_out   = exm_alu_out;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_rd         <= '0;
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_rd         <= exm_rd;
            wb_reg_write  <= exm_ctrl.reg_write;
            wb_mem_to_reg <= exm_ctrl.mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        wb_alu_out   <= exm_alu_out;
        wb_load_data <= dmem_rdata;
    end

    assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_out;

    a_re_we_excl: assert property (@(posedge clk) disable iff (rst) !(dmem_re && dmem_we))
        else $error("dmem_re and dmem_we both high");

endmodule

// File: logic/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  rv_pkg::ex_ctrl_t  id_ctrl,
    input  rv_pkg::word_t     if_inst,
    input  rv_pkg::word_t     id_imm,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     mem_alu_out,
    input  rv_pkg::word_t     wb_data,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              mem_reg_write,
    input  logic              wb_reg_write,
    output rv_pkg::word_t     ex_alu_result,
    output rv_pkg::word_t     ex_store_data,
    output rv_pkg::reg_addr_t ex_rd,
    output logic              ex_reg_write,
    output logic              ex_mem_read,
    output rv_pkg::ex_ctrl_t  exm_ctrl,
    output rv_pkg::word_t     exm_alu_out,
    output rv_pkg::word_t     exm_store_data,
    output rv_pkg::reg_addr_t exm_rd
);

    rv_pkg::ex_ctrl_t  idex_ctrl;
    rv_pkg::word_t     idex_rs1_data;
    rv_pkg::word_t     idex_rs2_data;
    rv_pkg::word_t     idex_imm;
    rv_pkg::reg_addr_t idex_rs1;
    rv_pkg::reg_addr_t idex_rs2;
    rv_pkg::fwd_sel_t  fwd_a;
    rv_pkg::fwd_sel_t  fwd_b;
    rv_pkg::word_t     op_a;
    rv_pkg::word_t     op_b;

    // ========================================
    // ID/EX
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idex_ctrl <= '0;
            ex_rd     <= '0;
        end else begin
            idex_ctrl <= stall ? '0 : id_ctrl;  // bubble while ID holds
            ex_rd     <= if_inst[11:7];
        end
    end

    always_ff @(posedge clk) begin
        idex_rs1_data <= rs1_data;
        idex_rs2_data <= rs2_data;
        idex_imm      <= id_imm;
        idex_rs1      <= if_inst[19:15];
        idex_rs2      <= if_inst[24:20];
    end

    // MEM beats WB
    function automatic rv_pkg::fwd_sel_t pick(input rv_pkg::reg_addr_t rs);
        if (rs != '0 && mem_reg_write && mem_rd == rs)
            return rv_pkg::fwd_mem;
        if (rs != '0 && wb_reg_write && wb_rd == rs)
            return rv_pkg::fwd_wb;
        return rv_pkg::fwd_none;
    endfunction

    function automatic rv_pkg::word_t fwd_mux(input rv_pkg::fwd_sel_t sel,
                                              input rv_pkg::word_t raw);
        case (sel)
            rv_pkg::fwd_mem: return mem_alu_out;
            rv_pkg::fwd_wb:  return wb_data;
            default:         return raw;
        endcase
    endfunction

    assign fwd_a         = pick(idex_rs1);
    assign fwd_b         = pick(idex_rs2);
    assign op_a          = fwd_mux(fwd_a, idex_rs1_data);
    assign ex_store_data = fwd_mux(fwd_b, idex_rs2_data);
    assign op_b          = idex_ctrl.alu_src ? idex_imm : ex_store_data;

    assign ex_alu_result = (idex_ctrl.alu_op == rv_pkg::alu_sub) ? op_a - op_b : op_a + op_b;
    assign ex_reg_write  = idex_ctrl.reg_write;
    assign ex_mem_read   = idex_ctrl.mem_read;

    // ========================================
    // EX/MEM
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exm_ctrl <= '0;
            exm_rd   <= '0;
        end else begin
            exm_ctrl <= idex_ctrl;
            exm_rd   <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        exm_alu_out    <= ex_alu_result;
        exm_store_data <= ex_store_data;  // forwarded rs2
    end

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  rv_pkg::word_t     if_inst,
    input  rv_pkg::word_t     if_pc,
    input  rv_pkg::word_t     id_imm,
    input  rv_pkg::word_t     rs1_data,
    input  rv_pkg::word_t     rs2_data,
    input  rv_pkg::word_t     ex_alu_result,
    input  rv_pkg::word_t     mem_alu_out,
    input  rv_pkg::word_t     wb_data,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::reg_addr_t mem_rd,
    input  rv_pkg::reg_addr_t wb_rd,
    input  logic              ex_reg_write,
    input  logic              mem_reg_write,
    input  logic              wb_reg_write,
    input  logic              stall,
    output logic              branch_taken,
    output rv_pkg::word_t     branch_target
);

    rv_pkg::word_t op_a;
    rv_pkg::word_t op_b;
    logic          cond;

    // youngest producer first
    function automatic rv_pkg::word_t resolve(input rv_pkg::reg_addr_t rs,
                                              input rv_pkg::word_t rf_val);
        if (rs == '0)
            return rf_val;
        if (ex_reg_write && ex_rd == rs)
            return ex_alu_result;
        if (mem_reg_write && mem_rd == rs)
            return mem_alu_out;
        if (wb_reg_write && wb_rd == rs)
            return wb_data;
        return rf_val;
    endfunction

    assign op_a = resolve(if_inst[19:15], rs1_data);
    assign op_b = resolve(if_inst[24:20], rs2_data);

    always_comb begin
        case (if_inst[14:12])
            rv_pkg::f3_beq:  cond = (op_a == op_b);
            rv_pkg::f3_bne:  cond = (op_a != op_b);
            rv_pkg::f3_blt:  cond = ($signed(op_a) <  $signed(op_b));
            rv_pkg::f3_bge:  cond = ($signed(op_a) >= $signed(op_b));
            rv_pkg::f3_bltu: cond = (op_a <  op_b);
            rv_pkg::f3_bgeu: cond = (op_a >= op_b);
            default:         cond = 1'b0;
        endcase
    end

    // operands not final while stalled
    assign branch_taken  = (if_inst[6:0] == rv_pkg::op_branch) && cond && !stall;
    assign branch_target = if_pc + id_imm;

endmodule

// File: logic/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
    input  rv_pkg::word_t     if_inst,
    input  rv_pkg::reg_addr_t ex_rd,
    input  rv_pkg::reg_addr_t mem_rd,
    input  logic              ex_mem_read,
    input  logic              mem_mem_read,
    output logic              stall
);

    rv_pkg::reg_addr_t rs1;
    rv_pkg::reg_addr_t rs2;
    logic              is_branch;
    logic              load_use;
    logic              branch_load;

    assign rs1       = if_inst[19:15];
    assign rs2       = if_inst[24:20];
    assign is_branch = (if_inst[6:0] == rv_pkg::op_branch);

    // ========================================
    // distance 1, any consumer
    // ========================================
    assign load_use = ex_mem_read && (ex_rd != '0)
                      && (ex_rd == rs1 || ex_rd == rs2);

    // ========================================
    // distance 2, branch only
    // ========================================
    // load data is picked up from WB a cycle later, no MEM path into ID
    assign branch_load = is_branch && mem_mem_read && (mem_rd != '0)
                         && (mem_rd == rs1 || mem_rd == rs2);

    assign stall = load_use || branch_load;

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              rst,
    input  rv_pkg::reg_addr_t rs1_addr,
    input  rv_pkg::reg_addr_t rs2_addr,
    input  rv_pkg::reg_addr_t rd_addr,
    input  rv_pkg::word_t     w_data,
    input  logic              reg_write,
    output rv_pkg::word_t     rs1_data,
    output rv_pkg::word_t     rs2_data
);

    rv_pkg::word_t regs [32];
    logic          wr_en;

    assign wr_en = reg_write && (rd_addr != '0);  // x0 never written

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_en) begin
            regs[rd_addr] <= w_data;
        end
    end

    // write in the same cycle shows through
    assign rs1_data = (wr_en && rd_addr == rs1_addr) ? w_data : regs[rs1_addr];
    assign rs2_data = (wr_en && rd_addr == rs2_addr) ? w_data : regs[rs2_addr];

    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        !(rs1_addr == '0 && rs1_data != '0) && !(rs2_addr == '0 && rs2_data != '0))
        else $error("x0 read back nonzero");

endmodule

// File: logic/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  rv_pkg::word_t    if_inst,
    output rv_pkg::ex_ctrl_t id_ctrl,
    output rv_pkg::word_t    id_imm
);

    logic [6:0] opcode;
    logic [6:0] funct7;

    assign opcode = if_inst[6:0];
    assign funct7 = if_inst[31:25];

    // ========================================
    // control bits
    // ========================================
    always_comb begin
        id_ctrl = '0;  // unknown opcode -> bubble
        case (opcode)
            rv_pkg::op_r_type: begin
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_op    = (funct7 == rv_pkg::funct7_sub) ? rv_pkg::alu_sub
                                                                   : rv_pkg::alu_add;
            end
            rv_pkg::op_i_type: begin
                id_ctrl.reg_write = 1'b1;
                id_ctrl.alu_src   = 1'b1;
            end
            rv_pkg::op_load: begin
                id_ctrl.reg_write  = 1'b1;
                id_ctrl.mem_read   = 1'b1;
                id_ctrl.mem_to_reg = 1'b1;
                id_ctrl.alu_src    = 1'b1;  // address = rs1 + imm
            end
            rv_pkg::op_store: begin
                id_ctrl.mem_write = 1'b1;
                id_ctrl.alu_src   = 1'b1;
            end
            default: ;  // branches finish in ID
        endcase
    end

    // ========================================
    // immediates
    // ========================================
    always_comb begin
        case (opcode)
            rv_pkg::op_i_type, rv_pkg::op_load:
                id_imm = {{20{if_inst[31]}}, if_inst[31:20]};
            rv_pkg::op_store:
                id_imm = {{20{if_inst[31]}}, if_inst[31:25], if_inst[11:7]};
            rv_pkg::op_branch:  // bits 12, 10:5, 4:1, 11
                id_imm = {{20{if_inst[31]}}, if_inst[7], if_inst[30:25],
                          if_inst[11:8], 1'b0};
            default:
                id_imm = '0;
        endcase
    end

endmodule

// File: logic/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic          clk,
    input  logic          rst,
    input  logic          stall,
    input  logic          branch_taken,
    input  rv_pkg::word_t branch_target,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t imem_addr,
    output rv_pkg::word_t if_pc,
    output rv_pkg::word_t if_inst
);

    rv_pkg::word_t pc;

    assign imem_addr = pc;  // instruction comes back same cycle

    // taken branch wins over stall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= rv_pkg::reset_pc;
            if_inst <= rv_pkg::nop_inst;
        end else if (branch_taken) begin
            pc      <= branch_target;
            if_inst <= rv_pkg::nop_inst;  // squash wrong-path fetch
        end else if (!stall) begin
            pc      <= pc + 32'd4;
            if_inst <= imem_data;
        end
    end

    // pc of a squashed slot is never looked at
    always_ff @(posedge clk) begin
        if (!stall)
            if_pc <= pc;
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// File: logic/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0] word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef enum logic [0:0] {
        alu_add = 1'b0,
        alu_sub = 1'b1
    } alu_op_t;

    // EX operand source
    typedef enum logic [1:0] {
        fwd_none = 2'b00,
        fwd_mem  = 2'b01,
        fwd_wb   = 2'b10
    } fwd_sel_t;

    // ========================================
    // encodings
    // ========================================
    localparam logic [6:0] op_r_type = 7'b0110011;
    localparam logic [6:0] op_i_type = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    localparam logic [6:0] funct7_sub = 7'b0100000;

    localparam word_t nop_inst = 32'h00000013;  // addi x0, x0, 0
    localparam word_t reset_pc = 32'h00000000;

    // control bits carried down the pipe
    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    mem_to_reg;
        logic    alu_src;
        alu_op_t alu_op;
    } ex_ctrl_t;

endpackage
